// File: hw/stream_pkg.sv
/*
 * Shared widths, page geometry and splitter encodings for the request front end.
 * Modules pull these in with a wildcard import in their headers.
 */
`default_nettype none

package stream_pkg;

  //////////////////////////////////////////////////
  // Request and burst widths
  //////////////////////////////////////////////////
  localparam int addr_width        = 32;
  // Length is carried as beats minus one
  localparam int len_width         = 8;
  // Holds up to 256 beats
  localparam int burst_count_width = 9;

  //////////////////////////////////////////////////
  // Page and beat geometry
  //////////////////////////////////////////////////
  localparam int page_offset_width = 12;
  localparam int page_num_width    = addr_width - page_offset_width;
  localparam int page_size         = 4096;
  localparam int beat_bytes        = 8;
  localparam int beat_offset_width = $clog2(beat_bytes);
  localparam int beats_per_page    = page_size / beat_bytes;
  // Beat index within a page
  localparam int page_beat_width   = page_offset_width - beat_offset_width;

  //////////////////////////////////////////////////
  // Splitter control
  //////////////////////////////////////////////////
  localparam int outstanding_max   = 15;
  localparam int outstanding_width = 4;

  localparam int state_width = 2;
  localparam logic [state_width-1:0] st_idle  = 2'd0;
  localparam logic [state_width-1:0] st_req   = 2'd1;
  localparam logic [state_width-1:0] st_next  = 2'd2;
  localparam logic [state_width-1:0] st_final = 2'd3;

  // One address word, seen either as a byte address or as page plus offset
  typedef union packed {
    logic [addr_width-1:0] flat;
    struct packed {
      logic [page_num_width-1:0]    page;
      logic [page_offset_width-1:0] offset;
    } paged;
  } stream_addr_u;

endpackage : stream_pkg

`default_nettype wire

// File: hw/page_burst_calc.sv
/*
 * Cuts one burst off the front of a request so it stays inside its 4 KB page.
 * Pure combinational, used by each splitter on the request or the remainder.
 */
`default_nettype none

module page_burst_calc
  import stream_pkg::*;
(
  input  wire stream_addr_u                  addr,
  input  wire [burst_count_width-1:0]        beats_left,
  output logic [burst_count_width-1:0]       burst_beats,
  output stream_addr_u                       next_addr,
  output logic [burst_count_width-1:0]       next_beats_left,
  output logic                               last
);

  logic [page_beat_width-1:0] beat_idx;
  // One bit wider since a page start leaves a full 512 beats
  logic [page_beat_width:0]   room;

  // Low address bits below a beat are ignored
  assign beat_idx = addr.paged.offset[page_offset_width-1:beat_offset_width];
  assign room     = (page_beat_width+1)'(beats_per_page) - {1'b0, beat_idx};

  // Whole remainder fits before the page end
  assign last = ({1'b0, beats_left} <= room);

  // When not last, room is below beats_left and so fits in 9 bits
  assign burst_beats = last ? beats_left : room[burst_count_width-1:0];

  assign next_beats_left = beats_left - burst_beats;

  // Next burst starts at the top of the following page
  always_comb begin
    next_addr.paged.page   = addr.paged.page + 1'b1;
    next_addr.paged.offset = '0;
  end

endmodule : page_burst_calc

`default_nettype wire

// File: hw/burst_splitter.sv
/*
 * Request splitter for one direction. Takes addr/len/flush requests, issues
 * page-bounded bursts to the arbiter and tracks bursts still in flight.
 */
`default_nettype none

module burst_splitter
  import stream_pkg::*;
#(
  // Writes take a new request while still finalizing
  parameter bit early_accept = 1'b0
) (
  input  wire                          clk,
  input  wire                          rst_n,

  input  wire [addr_width-1:0]         req_addr,
  input  wire [len_width-1:0]          req_len,
  input  wire                          req_flush,
  input  wire                          req_val,
  output logic                         req_rdy,
  output logic                         busy,

  output logic                         burst_val,
  output logic [addr_width-1:0]        burst_addr,
  output logic [burst_count_width-1:0] burst_beats,
  output logic                         burst_flush,
  output logic                         burst_last,
  input  wire                          burst_grant,

  input  wire                          burst_done
);

  logic [state_width-1:0]       state_r;
  logic [state_width-1:0]       state_nxt;
  logic                         accept;
  logic                         use_next;
  logic                         reg_en;
  logic                         issued;
  logic                         at_limit;

  stream_addr_u                 calc_addr;
  stream_addr_u                 calc_next_addr;
  logic [burst_count_width-1:0] calc_beats_left;
  logic [burst_count_width-1:0] calc_burst_beats;
  logic [burst_count_width-1:0] calc_next_beats;
  logic                         calc_last;

  stream_addr_u                 addr_r;
  stream_addr_u                 next_addr_r;
  logic [burst_count_width-1:0] beats_r;
  logic [burst_count_width-1:0] next_beats_r;
  logic                         last_r;
  logic                         flush_r;
  logic [outstanding_width-1:0] out_cnt_r;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  // Fresh request or the stored remainder
  always_comb begin
    if (use_next) begin
      calc_addr       = next_addr_r;
      calc_beats_left = next_beats_r;
    end else begin
      calc_addr.flat  = req_addr;
      calc_beats_left = {1'b0, req_len} + 1'b1;
    end
  end

  page_burst_calc calc (
    .addr            (calc_addr),
    .beats_left      (calc_beats_left),
    .burst_beats     (calc_burst_beats),
    .next_addr       (calc_next_addr),
    .next_beats_left (calc_next_beats),
    .last            (calc_last)
  );

  always_ff @(posedge clk) begin
    if (reg_en) begin
      addr_r       <= calc_addr;
      beats_r      <= calc_burst_beats;
      last_r       <= calc_last;
      next_addr_r  <= calc_next_addr;
      next_beats_r <= calc_next_beats;
    end
    if (accept) begin
      flush_r <= req_flush;
    end
  end

  assign burst_addr  = addr_r.flat;
  assign burst_beats = beats_r;
  assign burst_flush = flush_r;
  assign burst_last  = last_r;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  assign req_rdy  = (state_r == st_idle) || (early_accept && (state_r == st_final));
  assign busy     = (state_r != st_idle);
  assign use_next = (state_r == st_next);
  assign accept   = req_rdy && req_val;
  assign reg_en   = accept || use_next;
  assign at_limit = (out_cnt_r == outstanding_width'(outstanding_max));
  // Held back while the memory side has too many bursts open
  assign burst_val = (state_r == st_req) && !at_limit;
  assign issued    = burst_val && burst_grant;

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      st_idle: begin
        if (req_val) begin
          state_nxt = st_req;
        end
      end
      st_req: begin
        if (issued) begin
          state_nxt = last_r ? st_final : st_next;
        end
      end
      st_next: begin
        state_nxt = st_req;
      end
      default: begin
        // Wait for every issued burst to report done
        if (accept) begin
          state_nxt = st_req;
        end else if (out_cnt_r == '0) begin
          state_nxt = st_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_r   <= st_idle;
      out_cnt_r <= '0;
    end else begin
      state_r <= state_nxt;
      if (issued && !burst_done) begin
        out_cnt_r <= out_cnt_r + 1'b1;
      end else if (!issued && burst_done) begin
        out_cnt_r <= out_cnt_r - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // Grants only come for an offered burst, never one held back at the limit
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    burst_grant |-> burst_val);

  // Memory side only completes bursts it was given
  a_done_has_burst: assert property (@(posedge clk) disable iff (!rst_n)
    burst_done |-> out_cnt_r != '0);

  a_burst_stable: assert property (@(posedge clk) disable iff (!rst_n)
    burst_val && !burst_grant |=> burst_val && $stable(burst_addr)
      && $stable(burst_beats) && $stable(burst_flush) && $stable(burst_last));

endmodule : burst_splitter

`default_nettype wire

// File: hw/cmd_arbiter.sv
/*
 * Round-robin merge of the read and write burst streams into one registered
 * memory command slot. The slot refills in the cycle its command is taken.
 */
`default_nettype none

module cmd_arbiter
  import stream_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst_n,

  input  wire                          rd_burst_val,
  input  wire [addr_width-1:0]         rd_burst_addr,
  input  wire [burst_count_width-1:0]  rd_burst_beats,
  input  wire                          rd_burst_flush,
  input  wire                          rd_burst_last,
  output logic                         rd_burst_grant,

  input  wire                          wr_burst_val,
  input  wire [addr_width-1:0]         wr_burst_addr,
  input  wire [burst_count_width-1:0]  wr_burst_beats,
  input  wire                          wr_burst_flush,
  input  wire                          wr_burst_last,
  output logic                         wr_burst_grant,

  output logic                         cmd_valid,
  output logic                         cmd_write,
  output logic [addr_width-1:0]        cmd_addr,
  output logic [burst_count_width-1:0] cmd_beats,
  output logic                         cmd_flush,
  output logic                         cmd_last,
  input  wire                          cmd_ready
);

  logic         slot_free;
  logic         pick_wr;
  logic         grant_any;
  logic         last_wr_r;
  stream_addr_u slot_addr;

  //////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////
  always_comb begin
    slot_free = !cmd_valid || cmd_ready;
    // Alternate when both sides want the slot
    pick_wr        = wr_burst_val && (!rd_burst_val || !last_wr_r);
    wr_burst_grant = slot_free && pick_wr;
    rd_burst_grant = slot_free && rd_burst_val && !pick_wr;
    grant_any      = rd_burst_grant || wr_burst_grant;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
      last_wr_r <= 1'b0;
    end else if (slot_free) begin
      cmd_valid <= grant_any;
      if (grant_any) begin
        last_wr_r <= pick_wr;
      end
    end
  end

  //////////////////////////////////////////////////
  // Command slot
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_burst_grant) begin
      cmd_write      <= 1'b1;
      slot_addr.flat <= wr_burst_addr;
      cmd_beats      <= wr_burst_beats;
      cmd_flush      <= wr_burst_flush;
      cmd_last       <= wr_burst_last;
    end else if (rd_burst_grant) begin
      cmd_write      <= 1'b0;
      slot_addr.flat <= rd_burst_addr;
      cmd_beats      <= rd_burst_beats;
      cmd_flush      <= rd_burst_flush;
      cmd_last       <= rd_burst_last;
    end
  end

  assign cmd_addr = slot_addr.flat;

  // Command held while the memory side stalls
  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_write) && $stable(cmd_addr)
      && $stable(cmd_beats) && $stable(cmd_flush) && $stable(cmd_last));

endmodule : cmd_arbiter

`default_nettype wire

// File: hw/stream_cmd_top.sv
/*
 * Request front end top level. Read and write splitters side by side,
 * merged by the arbiter onto one memory command port.
 */
`default_nettype none

module stream_cmd_top
  import stream_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst_n,

  input  wire [addr_width-1:0]         rd_req_addr,
  input  wire [len_width-1:0]          rd_req_len,
  input  wire                          rd_req_flush,
  input  wire                          rd_req_val,
  output logic                         rd_req_rdy,
  output logic                         rd_busy,

  input  wire [addr_width-1:0]         wr_req_addr,
  input  wire [len_width-1:0]          wr_req_len,
  input  wire                          wr_req_flush,
  input  wire                          wr_req_val,
  output logic                         wr_req_rdy,
  output logic                         wr_busy,

  output logic                         cmd_valid,
  output logic                         cmd_write,
  output logic [addr_width-1:0]        cmd_addr,
  output logic [burst_count_width-1:0] cmd_beats,
  output logic                         cmd_flush,
  output logic                         cmd_last,
  input  wire                          cmd_ready,

  input  wire                          rd_burst_done,
  input  wire                          wr_burst_done
);

  // One set of splitter to arbiter wires per direction
  logic                         rd_burst_val, wr_burst_val;
  stream_addr_u                 rd_burst_addr, wr_burst_addr;
  logic [burst_count_width-1:0] rd_burst_beats, wr_burst_beats;
  logic                         rd_burst_flush, wr_burst_flush;
  logic                         rd_burst_last, wr_burst_last;
  logic                         rd_burst_grant, wr_burst_grant;

  burst_splitter #(.early_accept(1'b0)) rd_splitter (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_addr    (rd_req_addr),
    .req_len     (rd_req_len),
    .req_flush   (rd_req_flush),
    .req_val     (rd_req_val),
    .req_rdy     (rd_req_rdy),
    .busy        (rd_busy),
    .burst_val   (rd_burst_val),
    .burst_addr  (rd_burst_addr.flat),
    .burst_beats (rd_burst_beats),
    .burst_flush (rd_burst_flush),
    .burst_last  (rd_burst_last),
    .burst_grant (rd_burst_grant),
    .burst_done  (rd_burst_done)
  );

  burst_splitter #(.early_accept(1'b1)) wr_splitter (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_addr    (wr_req_addr),
    .req_len     (wr_req_len),
    .req_flush   (wr_req_flush),
    .req_val     (wr_req_val),
    .req_rdy     (wr_req_rdy),
    .busy        (wr_busy),
    .burst_val   (wr_burst_val),
    .burst_addr  (wr_burst_addr.flat),
    .burst_beats (wr_burst_beats),
    .burst_flush (wr_burst_flush),
    .burst_last  (wr_burst_last),
    .burst_grant (wr_burst_grant),
    .burst_done  (wr_burst_done)
  );

  cmd_arbiter arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_burst_val   (rd_burst_val),
    .rd_burst_addr  (rd_burst_addr.flat),
    .rd_burst_beats (rd_burst_beats),
    .rd_burst_flush (rd_burst_flush),
    .rd_burst_last  (rd_burst_last),
    .rd_burst_grant (rd_burst_grant),
    .wr_burst_val   (wr_burst_val),
    .wr_burst_addr  (wr_burst_addr.flat),
    .wr_burst_beats (wr_burst_beats),
    .wr_burst_flush (wr_burst_flush),
    .wr_burst_last  (wr_burst_last),
    .wr_burst_grant (wr_burst_grant),
    .cmd_valid      (cmd_valid),
    .cmd_write      (cmd_write),
    .cmd_addr       (cmd_addr),
    .cmd_beats      (cmd_beats),
    .cmd_flush      (cmd_flush),
    .cmd_last       (cmd_last),
    .cmd_ready      (cmd_ready)
  );

endmodule : stream_cmd_top

`default_nettype wire

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and reset source. 10 ns clock, reset held low for three
 * cycles and released on a falling edge.
 */
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

// File: verif/stream_cmd_tb.sv
/*
 * Testbench for the request front end. Applies a request table to both
 * directions, models the memory side and checks every command in order.
 */
`default_nettype none

module stream_cmd_tb
  import stream_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_entries      = 12;
  localparam int cycles_per_entry = 300;
  localparam int cycle_limit      = num_entries * cycles_per_entry;

  logic                         clk;
  logic                         rst_n;
  logic [addr_width-1:0]        rd_req_addr;
  logic [len_width-1:0]         rd_req_len;
  logic                         rd_req_flush;
  logic                         rd_req_val;
  logic                         rd_req_rdy;
  logic                         rd_busy;
  logic [addr_width-1:0]        wr_req_addr;
  logic [len_width-1:0]         wr_req_len;
  logic                         wr_req_flush;
  logic                         wr_req_val;
  logic                         wr_req_rdy;
  logic                         wr_busy;
  logic                         cmd_valid;
  logic                         cmd_write;
  logic [addr_width-1:0]        cmd_addr;
  logic [burst_count_width-1:0] cmd_beats;
  logic                         cmd_flush;
  logic                         cmd_last;
  logic                         cmd_ready;
  logic                         rd_burst_done;
  logic                         wr_burst_done;

  // Row layout {write, addr[31:0], len[7:0], flush, gap[3:0]}
  logic [45:0] stim_table [num_entries];
  // Burst layout {addr[31:0], beats[8:0], flush, last}
  logic [42:0] rd_exp_q [$];
  logic [42:0] wr_exp_q [$];
  int          rd_due_q [$];
  int          wr_due_q [$];
  bit          rd_due_last_q [$];
  bit          wr_due_last_q [$];
  int          rd_last_due = 0;
  int          wr_last_due = 0;
  int          rd_open = 0;
  int          wr_open = 0;
  int          cycle_count = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;
  int          early_accepts = 0;
  integer      seed = 98029;
  logic        hold_valid = 1'b0;
  logic [43:0] hold_cmd;

  tb_clock_gen clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  stream_cmd_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_req_addr   (rd_req_addr),
    .rd_req_len    (rd_req_len),
    .rd_req_flush  (rd_req_flush),
    .rd_req_val    (rd_req_val),
    .rd_req_rdy    (rd_req_rdy),
    .rd_busy       (rd_busy),
    .wr_req_addr   (wr_req_addr),
    .wr_req_len    (wr_req_len),
    .wr_req_flush  (wr_req_flush),
    .wr_req_val    (wr_req_val),
    .wr_req_rdy    (wr_req_rdy),
    .wr_busy       (wr_busy),
    .cmd_valid     (cmd_valid),
    .cmd_write     (cmd_write),
    .cmd_addr      (cmd_addr),
    .cmd_beats     (cmd_beats),
    .cmd_flush     (cmd_flush),
    .cmd_last      (cmd_last),
    .cmd_ready     (cmd_ready),
    .rd_burst_done (rd_burst_done),
    .wr_burst_done (wr_burst_done)
  );

  //////////////////////////////////////////////////
  // Reporting and expected model
  //////////////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errors++;
    $display("CHECK FAILED %s: got 0x%h expected 0x%h at cycle %0d",
             name, got, exp, cycle_count);
  endtask

  task automatic report_protocol(input string what);
    protocol_errors++;
    $display("ERROR: %s (cycle %0d)", what, cycle_count);
  endtask

  // Cut a request into page-bounded bursts
  task automatic add_expected(input bit write, input logic [31:0] addr,
                              input logic [7:0] len, input bit flush);
    logic [31:0] a;
    logic [42:0] burst;
    int          n;
    int          room;
    a = addr;
    n = int'(len) + 1;
    while (n > 0) begin
      room = beats_per_page - int'(a % page_size) / beat_bytes;
      if (n <= room) begin
        burst = {a, 9'(n), flush, 1'b1};
        n = 0;
      end else begin
        burst = {a, 9'(room), flush, 1'b0};
        a = a - (a % page_size) + page_size;
        n = n - room;
      end
      if (write)
        wr_exp_q.push_back(burst);
      else
        rd_exp_q.push_back(burst);
    end
  endtask

  task automatic compare_fields(input logic [42:0] exp);
    if (cmd_addr !== exp[42:11])
      report_mismatch("cmd_addr", cmd_addr, exp[42:11]);
    if (cmd_beats !== exp[10:2])
      report_mismatch("cmd_beats", cmd_beats, exp[10:2]);
    if (cmd_flush !== exp[1])
      report_mismatch("cmd_flush", cmd_flush, exp[1]);
    if (cmd_last !== exp[0])
      report_mismatch("cmd_last", cmd_last, exp[0]);
  endtask

  // Compare a command taken at the coming rising edge and schedule its done
  task automatic take_command();
    logic [42:0] exp;
    int          due;
    bit          exp_last;
    exp_last = 1'b0;
    due = cycle_count + 2 + int'({$random(seed)} % 5);
    if (cmd_write) begin
      if (wr_exp_q.size() == 0) begin
        report_protocol("write command arrived with no write burst expected");
      end else begin
        exp = wr_exp_q.pop_front();
        exp_last = exp[0];
        compare_fields(exp);
      end
      if (due <= wr_last_due)
        due = wr_last_due + 1;
      wr_last_due = due;
      wr_due_q.push_back(due);
      wr_due_last_q.push_back(exp_last);
    end else begin
      if (rd_exp_q.size() == 0) begin
        report_protocol("read command arrived with no read burst expected");
      end else begin
        exp = rd_exp_q.pop_front();
        exp_last = exp[0];
        compare_fields(exp);
      end
      if (due <= rd_last_due)
        due = rd_last_due + 1;
      rd_last_due = due;
      rd_due_q.push_back(due);
      rd_due_last_q.push_back(exp_last);
    end
  endtask

  //////////////////////////////////////////////////
  // One request driver process per direction
  //////////////////////////////////////////////////
  task automatic run_requests(input bit write);
    logic [45:0] row;
    int          i;
    for (i = 0; i < num_entries; i++) begin
      row = stim_table[i];
      if (row[45] == write) begin
        repeat (row[3:0]) @(negedge clk);
        if (write) begin
          wr_req_addr  = row[44:13];
          wr_req_len   = row[12:5];
          wr_req_flush = row[4];
          wr_req_val   = 1'b1;
        end else begin
          rd_req_addr  = row[44:13];
          rd_req_len   = row[12:5];
          rd_req_flush = row[4];
          rd_req_val   = 1'b1;
        end
        // rdy comes from state only, so it is settled here
        while (!(write ? wr_req_rdy : rd_req_rdy))
          @(negedge clk);
        // Taken while the write side is still finalizing
        if (write && wr_busy)
          early_accepts++;
        @(negedge clk);
        if (write) begin
          wr_req_val = 1'b0;
          wr_open++;
        end else begin
          rd_req_val = 1'b0;
          rd_open++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Memory-side model and monitor
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run stopped after %0d cycles with requests unfinished", cycle_count);
      $display("Errors: %0d value mismatches, %0d protocol errors", value_errors,
               protocol_errors);
      $display("STATUS: FAIL");
      $finish;
    end else if (rst_n) begin
      if (rd_open > 0 && !rd_busy)
        report_protocol("rd_busy low while a read request is still open");
      if (wr_open > 0 && !wr_busy)
        report_protocol("wr_busy low while a write request is still open");
      // Stalled command must hold
      if (hold_valid) begin
        if (!cmd_valid) begin
          report_protocol("cmd_valid dropped before the command was accepted");
        end else begin
          if (cmd_write !== hold_cmd[43])
            report_mismatch("cmd_write", cmd_write, hold_cmd[43]);
          compare_fields(hold_cmd[42:0]);
        end
      end
      rd_burst_done = 1'b0;
      wr_burst_done = 1'b0;
      if (rd_due_q.size() > 0 && rd_due_q[0] == cycle_count) begin
        rd_burst_done = 1'b1;
        if (rd_due_last_q[0])
          rd_open--;
        rd_due_q.delete(0);
        rd_due_last_q.delete(0);
      end
      if (wr_due_q.size() > 0 && wr_due_q[0] == cycle_count) begin
        wr_burst_done = 1'b1;
        if (wr_due_last_q[0])
          wr_open--;
        wr_due_q.delete(0);
        wr_due_last_q.delete(0);
      end
      cmd_ready = ({$random(seed)} % 4) != 0;
      if (cmd_valid && cmd_ready)
        take_command();
      hold_valid = cmd_valid && !cmd_ready;
      hold_cmd   = {cmd_write, cmd_addr, cmd_beats, cmd_flush, cmd_last};
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    int i;
    rd_req_addr   = '0;
    rd_req_len    = '0;
    rd_req_flush  = 1'b0;
    rd_req_val    = 1'b0;
    wr_req_addr   = '0;
    wr_req_len    = '0;
    wr_req_flush  = 1'b0;
    wr_req_val    = 1'b0;
    cmd_ready     = 1'b0;
    rd_burst_done = 1'b0;
    wr_burst_done = 1'b0;

    // write, address, len, flush, start gap
    stim_table[0]  = {1'b0, 32'h0000_1000, 8'd3,   1'b0, 4'd0};
    stim_table[1]  = {1'b1, 32'h0000_2000, 8'd15,  1'b1, 4'd0};
    stim_table[2]  = {1'b0, 32'h0000_3F80, 8'd31,  1'b1, 4'd2};
    stim_table[3]  = {1'b1, 32'h0001_0FF8, 8'd255, 1'b0, 4'd0};
    stim_table[4]  = {1'b1, 32'h0002_0100, 8'd7,   1'b0, 4'd0};
    stim_table[5]  = {1'b0, 32'h1234_5FF8, 8'd255, 1'b1, 4'd0};
    stim_table[6]  = {1'b0, 32'h0000_0800, 8'd0,   1'b0, 4'd5};
    stim_table[7]  = {1'b1, 32'h0005_0E00, 8'd63,  1'b1, 4'd0};
    stim_table[8]  = {1'b1, 32'h0006_0E08, 8'd63,  1'b0, 4'd3};
    stim_table[9]  = {1'b0, 32'h0007_0000, 8'd255, 1'b0, 4'd1};
    stim_table[10] = {1'b1, 32'h0009_0000, 8'd0,   1'b1, 4'd0};
    stim_table[11] = {1'b0, 32'h7FFF_FF00, 8'd63,  1'b1, 4'd0};
    for (i = 0; i < num_entries; i++)
      add_expected(stim_table[i][45], stim_table[i][44:13], stim_table[i][12:5],
                   stim_table[i][4]);

    wait (rst_n === 1'b1);
    @(negedge clk);
    if (cmd_valid !== 1'b0)
      report_mismatch("cmd_valid", cmd_valid, 0);
    if (rd_busy !== 1'b0)
      report_mismatch("rd_busy", rd_busy, 0);
    if (wr_busy !== 1'b0)
      report_mismatch("wr_busy", wr_busy, 0);
    if (rd_req_rdy !== 1'b1)
      report_mismatch("rd_req_rdy", rd_req_rdy, 1);
    if (wr_req_rdy !== 1'b1)
      report_mismatch("wr_req_rdy", wr_req_rdy, 1);

    fork
      run_requests(1'b0);
      run_requests(1'b1);
    join

    // Drain until every burst is seen and both sides are idle
    while (rd_exp_q.size() != 0 || wr_exp_q.size() != 0 || rd_open != 0 || wr_open != 0
           || rd_busy || wr_busy)
      @(negedge clk);
    if (!rd_req_rdy || !wr_req_rdy || cmd_valid)
      report_protocol("front end not idle after the last request completed");
    if (early_accepts == 0)
      report_protocol("no write request was accepted while the write side was finalizing");

    $display("Errors: %0d value mismatches, %0d protocol errors", value_errors,
             protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : stream_cmd_tb

`default_nettype wire

// File: vlog.f
hw/stream_pkg.sv
hw/page_burst_calc.sv
hw/burst_splitter.sv
hw/cmd_arbiter.sv
hw/stream_cmd_top.sv
verif/tb_clock_gen.sv
verif/stream_cmd_tb.sv

// File: Makefile
# Verilator build and run for the request front end testbench

SIM = obj_dir/Vstream_cmd_tb

.PHONY: compile run clean

compile: $(SIM)

$(SIM): vlog.f hw/*.sv verif/*.sv
	verilator --binary --assert -Wno-fatal --top-module stream_cmd_tb -f vlog.f -o Vstream_cmd_tb

# Fails on a nonzero exit or when the log reports failure
run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
